//--- hdl/dmr_settings.svh
// Lockstep compute block settings
// Widths, buffer sizes, credit counts and the register map

`ifndef DMR_SETTINGS_SVH
`define DMR_SETTINGS_SVH

// Datapath
`define DMR_DATA_W 16
`define DMR_TAG_W 4

// Input buffer depth, also the number of input credits
`define DMR_OP_DEPTH 4

// Output credits handed out after reset
`define DMR_RSP_CREDITS 4

// Register map, 4-bit byte addresses
`define DMR_REG_STATUS 4'h0
`define DMR_REG_ERRCNT 4'h4
`define DMR_REG_INJECT 4'h8

// Read value for unmapped addresses
`define DMR_ERR_VAL 32'hBADCAB1E

`endif

//--- hdl/dmr_pkg.sv
// Shared types of the lockstep compute block
// Opcodes, redundancy states and the structs on every interface

`include "dmr_settings.svh"

package dmr_pkg;

  // Results are modulo 2^16, shifts use b[3:0]
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SHL = 3'd5,
    OP_SHR = 3'd6,
    OP_MUL = 3'd7  // Low half of the product
  } alu_op_e;

  // Readable through STATUS[2:1]
  typedef enum logic [1:0] {
    LOCKSTEP = 2'd0,
    SETBACK  = 2'd1,
    RESYNC   = 2'd2
  } dmr_state_e;

  typedef struct packed {
    alu_op_e                op;
    logic [`DMR_TAG_W-1:0]  tag;
    logic [`DMR_DATA_W-1:0] a;
    logic [`DMR_DATA_W-1:0] b;
  } op_req_t;

  typedef struct packed {
    logic [`DMR_TAG_W-1:0]  tag;
    logic [`DMR_DATA_W-1:0] result;
  } op_rsp_t;

  // Everything a core drives, compared between the two cores
  typedef struct packed {
    logic    pop;
    logic    valid;
    op_rsp_t rsp;
  } core_out_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

endpackage

//--- hdl/op_credit_fifo.sv
// Credit-managed input buffer
// Holds operations until a core decode stage takes them and
// hands a credit back to the source for each entry it releases

`timescale 1ns/100ps

`include "dmr_settings.svh"

module op_credit_fifo #(
  parameter int unsigned Depth = `DMR_OP_DEPTH
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  dmr_pkg::op_req_t push_data_i,
  input  logic             pop_i,
  output dmr_pkg::op_req_t head_o,
  output logic             not_empty_o,
  output logic             credit_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  dmr_pkg::op_req_t mem_q [Depth];
  logic [PtrW-1:0]  wr_ptr_q;
  logic [PtrW-1:0]  rd_ptr_q;
  logic [CntW-1:0]  count_q;
  logic             credit_q;
  logic             full;

  assign full        = (count_q == CntW'(Depth));
  assign not_empty_o = (count_q != '0);
  assign head_o      = mem_q[rd_ptr_q];
  assign credit_o    = credit_q;  // One pulse per released entry

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CntW'(push_i) - CntW'(pop_i);
      credit_q <= pop_i;
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Source spent a credit it did not hold
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full);

  // Cores only take from a non-empty head
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> not_empty_o);

endmodule

//--- hdl/alu_core.sv
// Pipelined 16-bit ALU core
// Decode, execute and writeback, one cycle each
// Stall freezes every stage, clear empties them

`timescale 1ns/100ps

`include "dmr_settings.svh"

module alu_core (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                stall_i,
  input  logic                clear_i,
  input  dmr_pkg::op_req_t    head_i,
  input  logic                not_empty_i,
  input  logic                inject_i,
  output dmr_pkg::core_out_t  core_o
);

  logic                   advance;
  logic                   pop;

  logic                   dec_valid_q;
  dmr_pkg::op_req_t       dec_op_q;

  logic [`DMR_DATA_W-1:0] ex_result;
  logic                   ex_valid_q;
  dmr_pkg::op_rsp_t       ex_rsp_q;

  logic                   wb_valid_q;
  dmr_pkg::op_rsp_t       wb_rsp_q;
  logic [`DMR_DATA_W-1:0] flip_mask;

  assign advance = !stall_i && !clear_i;
  assign pop     = not_empty_i && advance;  // Decode takes the head

  // Result function
  always_comb begin
    case (dec_op_q.op)
      dmr_pkg::OP_ADD: ex_result = dec_op_q.a + dec_op_q.b;
      dmr_pkg::OP_SUB: ex_result = dec_op_q.a - dec_op_q.b;
      dmr_pkg::OP_AND: ex_result = dec_op_q.a & dec_op_q.b;
      dmr_pkg::OP_OR:  ex_result = dec_op_q.a | dec_op_q.b;
      dmr_pkg::OP_XOR: ex_result = dec_op_q.a ^ dec_op_q.b;
      dmr_pkg::OP_SHL: ex_result = dec_op_q.a << dec_op_q.b[3:0];
      dmr_pkg::OP_SHR: ex_result = dec_op_q.a >> dec_op_q.b[3:0];
      dmr_pkg::OP_MUL: ex_result = dec_op_q.a * dec_op_q.b;  // Truncated to 16 bits
      default:         ex_result = '0;
    endcase
  end

  // Fault injection only touches bit 0 of a valid result
  assign flip_mask = {{(`DMR_DATA_W-1){1'b0}}, inject_i};

  // Stage valid flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dec_valid_q <= 1'b0;
      ex_valid_q  <= 1'b0;
      wb_valid_q  <= 1'b0;
    end else if (clear_i) begin
      dec_valid_q <= 1'b0;
      ex_valid_q  <= 1'b0;
      wb_valid_q  <= 1'b0;
    end else if (!stall_i) begin
      dec_valid_q <= pop;
      ex_valid_q  <= dec_valid_q;
      wb_valid_q  <= ex_valid_q;
    end
  end

  // Stage payloads, loaded only behind a valid flag
  always_ff @(posedge clk_i) begin
    if (pop) begin
      dec_op_q <= head_i;
    end
    if (advance && dec_valid_q) begin
      ex_rsp_q.tag    <= dec_op_q.tag;
      ex_rsp_q.result <= ex_result;
    end
    if (advance && ex_valid_q) begin
      wb_rsp_q.tag    <= ex_rsp_q.tag;
      wb_rsp_q.result <= ex_rsp_q.result ^ flip_mask;
    end
  end

  assign core_o.pop   = pop;
  assign core_o.valid = wb_valid_q;
  assign core_o.rsp   = wb_rsp_q;

  // Redundancy unit never flushes and freezes at once
  a_no_stall_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(stall_i && clear_i));

endmodule

//--- hdl/dmr_unit.sv
// Dual modular redundancy unit
// Compares both cores every cycle, flushes them on a mismatch,
// drives the credited result port and serves the status registers

`timescale 1ns/100ps

`include "dmr_settings.svh"

module dmr_unit (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  dmr_pkg::core_out_t core0_i,
  input  dmr_pkg::core_out_t core1_i,
  output logic               stall_o,
  output logic               clear_o,
  output logic               inject_o,
  output logic               pop_o,
  output logic               rsp_valid_o,
  output dmr_pkg::op_rsp_t   rsp_o,
  input  logic               rsp_credit_i,
  output logic               dmr_error_o,
  input  dmr_pkg::reg_req_t  reg_req_i,
  output dmr_pkg::reg_rsp_t  reg_rsp_o
);

  localparam int unsigned CntW = $clog2(`DMR_RSP_CREDITS + 1);

  dmr_pkg::dmr_state_e state_q;
  dmr_pkg::dmr_state_e state_d;
  logic                mismatch;
  logic                fire;

  logic [CntW-1:0]     credit_cnt_q;
  logic [CntW-1:0]     credit_avail;
  logic                rsp_valid_q;
  dmr_pkg::op_rsp_t    rsp_q;
  logic                error_q;

  logic                reg_wr;
  logic                sticky_q;
  logic [31:0]         errcnt_q;
  logic                inject_q;
  logic [31:0]         rd_data;
  logic                rd_error;
  dmr_pkg::reg_rsp_t   reg_rsp_q;

  // Payload only counts when the result is valid
  always_comb begin
    mismatch = 1'b0;
    if (state_q == dmr_pkg::LOCKSTEP) begin
      mismatch = (core0_i.pop != core1_i.pop) || (core0_i.valid != core1_i.valid) ||
                 (core0_i.valid && (core0_i.rsp != core1_i.rsp));
    end
  end

  // A credit is still tied up while the current result is on the port
  assign credit_avail = credit_cnt_q - CntW'(rsp_valid_q);

  assign fire = (state_q == dmr_pkg::LOCKSTEP) && core0_i.valid && !mismatch &&
                (credit_avail != '0);

  assign stall_o  = (state_q == dmr_pkg::RESYNC) ||
                    ((state_q == dmr_pkg::LOCKSTEP) && core0_i.valid && (credit_avail == '0));
  assign clear_o  = (state_q == dmr_pkg::SETBACK);
  assign pop_o    = core0_i.pop;  // Core 0 drives the buffer
  assign inject_o = inject_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dmr_pkg::LOCKSTEP: if (mismatch) state_d = dmr_pkg::SETBACK;
      dmr_pkg::SETBACK:  state_d = dmr_pkg::RESYNC;   // Flush both cores
      dmr_pkg::RESYNC:   state_d = dmr_pkg::LOCKSTEP;
      default:           state_d = dmr_pkg::LOCKSTEP;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= dmr_pkg::LOCKSTEP;
      credit_cnt_q <= CntW'(`DMR_RSP_CREDITS);
      rsp_valid_q  <= 1'b0;
      error_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      credit_cnt_q <= credit_cnt_q + CntW'(rsp_credit_i) - CntW'(rsp_valid_q);
      rsp_valid_q  <= fire;
      error_q      <= mismatch;
    end
  end

  // Output result register
  always_ff @(posedge clk_i) begin
    if (fire) begin
      rsp_q <= core0_i.rsp;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign dmr_error_o = error_q;

  assign reg_wr = reg_req_i.valid && reg_req_i.write;

  always_comb begin
    rd_data  = `DMR_ERR_VAL;
    rd_error = 1'b0;
    case (reg_req_i.addr)
      `DMR_REG_STATUS: rd_data = {29'b0, state_q, sticky_q};
      `DMR_REG_ERRCNT: rd_data = errcnt_q;
      `DMR_REG_INJECT: rd_data = {31'b0, inject_q};
      default:         rd_error = 1'b1;
    endcase
  end

  // Register file, a new mismatch wins over a software clear
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sticky_q  <= 1'b0;
      errcnt_q  <= '0;
      inject_q  <= 1'b0;
      reg_rsp_q <= '0;
    end else begin
      if (mismatch) begin
        sticky_q <= 1'b1;
      end else if (reg_wr && (reg_req_i.addr == `DMR_REG_STATUS) && reg_req_i.wdata[0]) begin
        sticky_q <= 1'b0;  // Write 1 to clear
      end
      if (reg_wr && (reg_req_i.addr == `DMR_REG_ERRCNT)) begin
        errcnt_q <= {31'b0, mismatch};
      end else if (mismatch) begin
        errcnt_q <= errcnt_q + 32'd1;
      end
      // The injected result always mismatches, which disarms
      if (reg_wr && (reg_req_i.addr == `DMR_REG_INJECT)) begin
        inject_q <= reg_req_i.wdata[0];
      end else if (mismatch) begin
        inject_q <= 1'b0;
      end
      reg_rsp_q.valid <= reg_req_i.valid;
      reg_rsp_q.error <= rd_error;
      reg_rsp_q.rdata <= rd_data;
    end
  end

  assign reg_rsp_o = reg_rsp_q;

  // Sink returned more credits than it was given
  a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_cnt_q <= CntW'(`DMR_RSP_CREDITS));

  a_valid_has_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |-> (credit_cnt_q != '0));

endmodule

//--- hdl/dmr_compute_top.sv
// Lockstep dual-core compute block
// Credited input buffer feeding two ALU cores behind a DMR unit

`timescale 1ns/100ps

module dmr_compute_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              op_valid_i,
  input  dmr_pkg::op_req_t  op_i,
  output logic              op_credit_o,
  output logic              rsp_valid_o,
  output dmr_pkg::op_rsp_t  rsp_o,
  input  logic              rsp_credit_i,
  output logic              dmr_error_o,
  input  dmr_pkg::reg_req_t reg_req_i,
  output dmr_pkg::reg_rsp_t reg_rsp_o
);

  dmr_pkg::op_req_t         head;
  logic                     not_empty;
  logic                     pop;
  logic                     stall;
  logic                     clear;
  logic                     inject;
  logic [1:0]               core_inject;
  dmr_pkg::core_out_t [1:0] core_out;

  op_credit_fifo i_op_fifo (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .push_i      ( op_valid_i  ),
    .push_data_i ( op_i        ),
    .pop_i       ( pop         ),
    .head_o      ( head        ),
    .not_empty_o ( not_empty   ),
    .credit_o    ( op_credit_o )
  );

  assign core_inject = {inject, 1'b0};  // Only core 1 can be corrupted

  for (genvar i = 0; i < 2; i++) begin : gen_cores
    alu_core i_alu_core (
      .clk_i       ( clk_i          ),
      .rst_n_i     ( rst_n_i        ),
      .stall_i     ( stall          ),
      .clear_i     ( clear          ),
      .head_i      ( head           ),
      .not_empty_i ( not_empty      ),
      .inject_i    ( core_inject[i] ),
      .core_o      ( core_out[i]    )
    );
  end

  dmr_unit i_dmr_unit (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .core0_i      ( core_out[0]  ),
    .core1_i      ( core_out[1]  ),
    .stall_o      ( stall        ),
    .clear_o      ( clear        ),
    .inject_o     ( inject       ),
    .pop_o        ( pop          ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .rsp_o        ( rsp_o        ),
    .rsp_credit_i ( rsp_credit_i ),
    .dmr_error_o  ( dmr_error_o  ),
    .reg_req_i    ( reg_req_i    ),
    .reg_rsp_o    ( reg_rsp_o    )
  );

endmodule

//--- tb/dmr_compute_tb.sv
// Testbench for the lockstep dual-core compute block
// Replays the vectors file through the credited ports, scoreboards
// every result and exercises the register bus and fault injection

`timescale 1ns/100ps

`include "dmr_settings.svh"

module dmr_compute_tb;

  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DLY     = 2;
  localparam int RESET_CYCLES  = 10;
  localparam int WDOG_CYCLES   = 60;  // Per record
  localparam int PIPE_LATENCY  = 4;   // Push edge to result edge
  localparam int RELEASE_CYCLES = 8;  // Per held result once credits flow again
  localparam int MAX_RECORDS   = 64;
  localparam int FIELDS        = 5;   // kind, op, a, b, expected
  localparam logic [3:0] UNMAPPED_ADDR = 4'hC;

  localparam logic [15:0] KIND_BURST  = 16'h0;
  localparam logic [15:0] KIND_HELD   = 16'h1;
  localparam logic [15:0] KIND_INJECT = 16'h2;
  localparam logic [15:0] KIND_END    = 16'hf;

  logic              clk;
  logic              rst_n;
  logic              op_valid;
  dmr_pkg::op_req_t  op_req;
  logic              op_credit;
  logic              rsp_valid;
  dmr_pkg::op_rsp_t  rsp;
  logic              rsp_credit;
  logic              dmr_error;
  dmr_pkg::reg_req_t reg_req;
  dmr_pkg::reg_rsp_t reg_rsp;

  logic [15:0]       vec_mem [MAX_RECORDS*FIELDS];
  int                num_records;
  dmr_pkg::op_rsp_t  exp_q[$];  // Expected results in tag order
  logic [3:0]        next_tag;
  integer            seed = 32'h762a38b8;

  int                credits;       // Input credits held by the source
  int                ops_sent;
  int                credit_pulses;
  int                rsp_count;
  int                owed;          // Output credits not yet returned
  int                err_pulses;
  int                injections;
  logic              hold_credits;
  logic              lat_armed;
  time               push_time;
  time               lat_time;

  dmr_compute_top UUT (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .op_valid_i   ( op_valid   ),
    .op_i         ( op_req     ),
    .op_credit_o  ( op_credit  ),
    .rsp_valid_o  ( rsp_valid  ),
    .rsp_o        ( rsp        ),
    .rsp_credit_i ( rsp_credit ),
    .dmr_error_o  ( dmr_error  ),
    .reg_req_i    ( reg_req    ),
    .reg_rsp_o    ( reg_rsp    )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    stop_run();
  endtask

  task automatic check_rsp(input string name, input dmr_pkg::op_rsp_t got,
                           input dmr_pkg::op_rsp_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_reg(input string name, input dmr_pkg::reg_rsp_t got,
                           input dmr_pkg::reg_rsp_t exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  function automatic logic [15:0] field(input int idx, input int f);
    return vec_mem[idx*FIELDS+f];
  endfunction

  function automatic dmr_pkg::reg_rsp_t reg_expect(input logic error, input logic [31:0] data);
    dmr_pkg::reg_rsp_t r;
    r.valid = 1'b1;
    r.error = error;
    r.rdata = data;
    return r;
  endfunction

  task automatic tick();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // One request and its response one cycle later
  task automatic reg_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output dmr_pkg::reg_rsp_t resp);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    tick();
    reg_req = '0;
    resp    = reg_rsp;
    tick();
    check_bit("reg_rsp_o.valid", reg_rsp.valid, 1'b0);  // Single-cycle response
  endtask

  task automatic read_reg(input logic [3:0] addr, input dmr_pkg::reg_rsp_t exp);
    dmr_pkg::reg_rsp_t r;
    reg_access(1'b0, addr, '0, r);
    check_reg("reg_rsp_o", r, exp);
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    dmr_pkg::reg_rsp_t r;
    reg_access(1'b1, addr, data, r);
    check_bit("reg_rsp_o.valid", r.valid, 1'b1);
    check_bit("reg_rsp_o.error", r.error, 1'b0);
  endtask

  // Issue one record once an input credit is free
  task automatic send_record(input int idx, input logic expect_rsp);
    dmr_pkg::op_req_t r;
    dmr_pkg::op_rsp_t e;
    logic [15:0]      op_field;
    op_field = field(idx, 1);
    r.op     = dmr_pkg::alu_op_e'(op_field[2:0]);
    r.tag    = next_tag;
    r.a      = field(idx, 2);
    r.b      = field(idx, 3);
    e.tag    = next_tag;
    e.result = field(idx, 4);
    while (credits == 0) begin
      op_valid = 1'b0;
      tick();
    end
    op_valid = 1'b1;
    op_req   = r;
    credits--;
    ops_sent++;
    next_tag++;
    if (expect_rsp) begin
      exp_q.push_back(e);
    end
    tick();
    op_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0 || owed != 0) begin
      tick();
    end
  endtask

  task automatic run_burst(inout int idx);
    int cycles;
    push_time = $time;
    lat_armed = 1'b1;
    while (field(idx, 0) == KIND_BURST) begin
      send_record(idx, 1'b1);
      idx++;
    end
    drain();
    cycles = int'((lat_time - push_time - (CLK_PERIOD - DRIVE_DLY) - CLK_PERIOD/2) / CLK_PERIOD);
    check_count("first result latency", cycles, PIPE_LATENCY);
  endtask

  // Output credits withheld until the pipeline has frozen
  task automatic run_held(inout int idx);
    int base;
    int n;
    int allowed;
    int waited;
    base         = rsp_count;
    n            = 0;
    hold_credits = 1'b1;
    while (field(idx, 0) == KIND_HELD) begin
      send_record(idx, 1'b1);
      idx++;
      n++;
    end
    allowed = (n < `DMR_RSP_CREDITS) ? n : `DMR_RSP_CREDITS;
    while (rsp_count - base < allowed) begin
      tick();
    end
    repeat (2 * `DMR_OP_DEPTH) tick();
    check_count("results with credits withheld", rsp_count - base, allowed);
    hold_credits = 1'b0;
    waited       = 0;
    while (rsp_count - base < n && waited < n * RELEASE_CYCLES) begin
      tick();
      waited++;
    end
    check_count("results after credit return", rsp_count - base, n);
    drain();
  endtask

  task automatic run_inject(inout int idx);
    dmr_pkg::reg_rsp_t r;
    int base_err;
    int polls;
    base_err = err_pulses;
    reg_write(`DMR_REG_INJECT, 32'h1);
    send_record(idx, 1'b0);
    idx++;
    injections++;
    while (err_pulses == base_err) begin
      tick();
    end
    polls = 0;
    reg_access(1'b0, `DMR_REG_STATUS, '0, r);
    while (r.rdata[2:1] != dmr_pkg::LOCKSTEP) begin
      polls++;
      if (polls > 4) begin
        abort_run("the redundancy unit did not return to lockstep after a mismatch");
      end
      reg_access(1'b0, `DMR_REG_STATUS, '0, r);
    end
    check_reg("reg_rsp_o", r, reg_expect(1'b0, {29'b0, dmr_pkg::LOCKSTEP, 1'b1}));
    check_count("dmr_error_o pulses", err_pulses - base_err, 1);
    read_reg(`DMR_REG_ERRCNT, reg_expect(1'b0, 32'd1));
    read_reg(`DMR_REG_INJECT, reg_expect(1'b0, 32'd0));  // Disarmed
    reg_write(`DMR_REG_ERRCNT, 32'h0);
    reg_write(`DMR_REG_STATUS, 32'h1);
    read_reg(`DMR_REG_STATUS, reg_expect(1'b0, 32'd0));
    read_reg(`DMR_REG_ERRCNT, reg_expect(1'b0, 32'd0));
  endtask

  // Samples outputs mid-cycle and returns output credits after the next edge
  initial begin : monitor
    logic credit_next;
    int   delay_left;
    credit_next = 1'b0;
    delay_left  = 0;
    forever begin
      @(negedge clk);
      credit_next = 1'b0;
      if (rst_n) begin
        if (rsp_valid) begin
          if (exp_q.size() == 0) begin
            abort_run("a result arrived with no operation outstanding");
          end else begin
            check_rsp("rsp_o", rsp, exp_q.pop_front());
            rsp_count++;
            owed++;
            if (lat_armed) begin
              lat_time  = $time;
              lat_armed = 1'b0;
            end
          end
        end
        if (op_credit) begin
          credits++;
          credit_pulses++;
          if (credits > `DMR_OP_DEPTH) begin
            abort_run("the buffer returned more input credits than were spent");
          end
        end
        if (dmr_error) begin
          err_pulses++;
        end
        if (owed > 0 && !hold_credits) begin
          if (delay_left == 0) begin
            credit_next = 1'b1;
            owed--;
            delay_left = $unsigned($random(seed)) % 4;
          end else begin
            delay_left--;
          end
        end
      end
      @(posedge clk);
      #DRIVE_DLY;
      rsp_credit = credit_next;
    end
  end

  initial begin : watchdog
    wait (num_records != 0);
    #(num_records * WDOG_CYCLES * CLK_PERIOD);
    abort_run("the watchdog expired before all records were processed");
  end

  initial begin : main
    int idx;
    rst_n         = 1'b0;
    op_valid      = 1'b0;
    op_req        = '0;
    rsp_credit    = 1'b0;
    reg_req       = '0;
    next_tag      = '0;
    credits       = `DMR_OP_DEPTH;
    ops_sent      = 0;
    credit_pulses = 0;
    rsp_count     = 0;
    owed          = 0;
    err_pulses    = 0;
    injections    = 0;
    hold_credits  = 1'b0;
    lat_armed     = 1'b0;
    num_records   = 0;
    $readmemh("tb/dmr_vectors.txt", vec_mem);
    idx = 0;
    while (idx < MAX_RECORDS && field(idx, 0) != KIND_END) begin
      idx++;
    end
    if (idx == 0) begin
      abort_run("the vectors file holds no records");
    end
    num_records = idx;

    repeat (RESET_CYCLES) tick();
    rst_n = 1'b1;
    check_bit("dmr_error_o", dmr_error, 1'b0);
    check_bit("rsp_valid_o", rsp_valid, 1'b0);
    check_bit("op_credit_o", op_credit, 1'b0);
    check_bit("reg_rsp_o.valid", reg_rsp.valid, 1'b0);
    read_reg(`DMR_REG_STATUS, reg_expect(1'b0, {29'b0, dmr_pkg::LOCKSTEP, 1'b0}));
    read_reg(`DMR_REG_ERRCNT, reg_expect(1'b0, 32'd0));

    idx = 0;
    while (idx < num_records) begin
      drain();
      case (field(idx, 0))
        KIND_BURST:  run_burst(idx);
        KIND_HELD:   run_held(idx);
        KIND_INJECT: run_inject(idx);
        default:     abort_run("the vectors file holds an unknown record kind");
      endcase
    end

    drain();
    read_reg(UNMAPPED_ADDR, reg_expect(1'b1, `DMR_ERR_VAL));
    check_count("op_credit_o pulses", credit_pulses, ops_sent);
    check_count("dmr_error_o pulses", err_pulses, injections);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- tb/dmr_vectors.txt
// Columns: kind op a b expected, all hex
// kind 0 burst, 1 output credits withheld, 2 injected (expected unused), f end
0 0 1234 0011 1245
0 1 0010 0020 fff0
0 2 f0f0 3c3c 3030
0 3 f0f0 0f0f ffff
0 4 aaaa ffff 5555
0 5 0001 0013 0008
0 6 8000 000f 0001
0 7 0100 0100 0000
0 7 00ff 0003 02fd
0 0 ffff 0002 0001
0 5 abcd 0004 bcd0
0 6 abcd 0108 00ab
// Back-pressure group
1 0 0100 0200 0300
1 1 0005 0007 fffe
1 7 1234 0010 2340
1 4 1234 4321 5115
1 3 1200 0034 1234
1 2 ffff 5a5a 5a5a
1 5 8001 0001 0002
1 6 7fff 0010 7fff
// Fault injection, then normal traffic
2 0 0001 0001 0000
0 0 7fff 0001 8000
0 1 0000 0001 ffff
0 7 ffff ffff 0001
0 4 0f0f 00ff 0ff0
0 6 1234 0004 0123
2 7 0003 0005 0000
0 7 0012 0034 03a8
0 0 8000 8000 0000
0 2 1357 0ff0 0350
0 5 0003 000e c000
0 1 1000 0001 0fff
f 0 0000 0000 0000

//--- src.f
+incdir+hdl
hdl/dmr_pkg.sv
hdl/op_credit_fifo.sv
hdl/alu_core.sv
hdl/dmr_unit.sv
hdl/dmr_compute_top.sv
tb/dmr_compute_tb.sv
